// ==== flist.f ====
source/mpu_pkg.sv
source/issue_queue.sv
source/thread_map.sv
source/dispatch_ctrl.sv
source/instr_mem.sv
source/mpu_dispatch_top.sv
verification/mpu_dispatch_chk.sv
verification/mpu_dispatch_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and pass only if the testbench printed its pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module mpu_dispatch_tb --Mdir obj_dir -o mpu_dispatch_sim \
	-f flist.f \
	&& ./obj_dir/mpu_dispatch_sim | tee /dev/stderr | grep -q "^=== PASS ===$" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// ==== verification/mpu_dispatch_tb.sv ====
module mpu_dispatch_tb;

	timeunit 1ns;
	timeprecision 100ps;

	typedef logic [mpu_pkg::thread_id_w-1:0]	tid_t;
	typedef logic [mpu_pkg::issue_no_w-1:0]		issue_no_t;
	typedef logic [mpu_pkg::addr_w-1:0]			addr_t;
	typedef logic [mpu_pkg::len_w-1:0]			len_t;
	typedef logic [mpu_pkg::word_w-1:0]			word_t;

	logic						clock;
	logic						reset;
	mpu_pkg::issue_req_t		issue;
	mpu_pkg::map_write_t		map_wr;
	mpu_pkg::mem_write_t		mem_wr;
	mpu_pkg::dispatch_out_t		dispatch;
	logic						overflow;

	// Shadow state for the reference model
	mpu_pkg::instr_t			mem_shadow [mpu_pkg::mem_depth];
	mpu_pkg::lookup_t			map_shadow [mpu_pkg::thread_count];
	mpu_pkg::dispatch_out_t		exp_q [$];		// Words still owed by the DUT

	string						test_name;
	int							errors;
	int							test_errors;
	int							words_checked;
	int							tests_done;

	mpu_dispatch_top DUT (
		.clock		(clock),
		.reset		(reset),
		.issue		(issue),
		.map_wr		(map_wr),
		.mem_wr		(mem_wr),
		.dispatch	(dispatch),
		.overflow	(overflow)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference model and checking
	////////////////////////////////////////////////////////////////////////////

	// Word idx of the packet for one request: three headers, then the program
	function automatic mpu_pkg::dispatch_out_t packet_word(input tid_t tid,
			input issue_no_t issue_no, input int idx);
		mpu_pkg::lookup_t		info;
		mpu_pkg::header_t		hdr;
		mpu_pkg::dispatch_out_t	w;
		info	= map_shadow[tid];
		hdr		= '0;
		w		= '0;
		w.valid	= 1'b1;
		if (idx < 3) begin
			w.is_header = 1'b1;
			case (idx)
				0: begin
					hdr.kind	= mpu_pkg::hdr_thread_id;
					hdr.value	= {{(mpu_pkg::hdr_value_w-mpu_pkg::thread_id_w){1'b0}}, tid};
				end
				1: begin
					hdr.kind	= mpu_pkg::hdr_issue_no;
					hdr.value	= issue_no;
				end
				default: begin
					hdr.kind	= mpu_pkg::hdr_length;
					hdr.value	= info.length;
				end
			endcase
			w.word.hdr = hdr;
		end
		else begin
			w.word.instr	= mem_shadow[addr_t'(int'(info.base) + idx - 3)];
			w.last			= idx == int'(info.length) + 2;
		end
		return w;
	endfunction

	task automatic check(input string name, input word_t expected, input word_t actual);
		if (expected !== actual) begin
			$display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
			errors++;
			test_errors++;
		end
	endtask

	task automatic report_error(input string msg);
		$display("ERROR %s: %s", test_name, msg);
		errors++;
		test_errors++;
	endtask

	// Compare on the falling edge, outputs are settled
	always @(negedge clock) begin : compare_words
		mpu_pkg::dispatch_out_t expected;
		if (!reset && dispatch.valid) begin
			if (exp_q.size() == 0) begin
				report_error($sformatf("word %h came out with no packet pending", dispatch.word));
			end
			else begin
				expected = exp_q.pop_front();
				check({test_name, " word"}, expected.word, dispatch.word);
				check({test_name, " is_header"}, word_t'(expected.is_header),
					word_t'(dispatch.is_header));
				check({test_name, " last"}, word_t'(expected.last), word_t'(dispatch.last));
				words_checked++;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	task automatic release_inputs();
		@(posedge clock);
		issue	<= '0;
		map_wr	<= '0;
		mem_wr	<= '0;
	endtask

	task automatic write_instr(input addr_t addr, input word_t data);
		@(posedge clock);
		mem_wr				<= '{valid: 1'b1, addr: addr, data: data};
		mem_shadow[addr]	= data;
	endtask

	// Random program words, then the map entry
	task automatic load_thread(input tid_t tid, input addr_t base, input len_t length);
		for (int i = 0; i < int'(length); i++) begin
			write_instr(addr_t'(int'(base) + i), $urandom);
		end
		@(posedge clock);
		mem_wr			<= '0;
		map_wr			<= '{valid: 1'b1, thread_id: tid, base: base, length: length};
		map_shadow[tid]	= '{base: base, length: length};
		release_inputs();
	endtask

	task automatic send_issue(input tid_t tid, input issue_no_t issue_no, input bit accepted);
		@(posedge clock);
		issue <= '{valid: 1'b1, thread_id: tid, issue_no: issue_no};
		if (accepted) begin
			for (int i = 0; i < int'(map_shadow[tid].length) + 3; i++) begin
				exp_q.push_back(packet_word(tid, issue_no, i));
			end
		end
	endtask

	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while (exp_q.size() != 0 && cycles < 2000) begin		// Far above the longest packet
			@(posedge clock);
			cycles++;
		end
		if (exp_q.size() != 0) begin
			report_error($sformatf("timed out with %0d expected words never sent", exp_q.size()));
			exp_q.delete();
		end
	endtask

	// First output word of a packet
	task automatic wait_valid();
		int cycles;
		cycles = 0;
		while (!dispatch.valid && cycles < 50) begin
			@(negedge clock);
			cycles++;
		end
		if (!dispatch.valid) begin
			report_error("no output word appeared after the issue");
		end
	endtask

	task automatic start_test(input string name);
		test_name	= name;
		test_errors	= 0;
	endtask

	task automatic end_test();
		tests_done++;
		$display("%s: %s, %0d errors", test_name, (test_errors == 0) ? "ok" : "failed", test_errors);
	endtask

	task automatic finish_run();
		$display("tests %0d, words checked %0d, errors %0d", tests_done, words_checked, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end
		else begin
			$display("=== FAIL ===");
		end
		$finish;
	endtask

	initial begin
		int		n_req;
		tid_t	tids [4];
		len_t	len;
		addr_t	base;
		void'($urandom(32'hd4a2ed5c));
		reset			= 1'b1;
		issue			= '0;
		map_wr			= '0;
		mem_wr			= '0;
		errors			= 0;
		test_errors		= 0;
		words_checked	= 0;
		tests_done		= 0;
		test_name		= "startup";
		foreach (map_shadow[i]) begin
			map_shadow[i] = '0;
		end
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		for (int a = 0; a < mpu_pkg::mem_depth; a++) begin
			write_instr(addr_t'(a), $urandom);
		end
		release_inputs();

		start_test("single_issue");
		load_thread(4'd3, 8'd16, 8'd6);
		send_issue(4'd3, 8'h21, 1'b1);
		release_inputs();
		wait_drain();
		end_test();

		start_test("length_limits");
		load_thread(4'd5, 8'd40, 8'd1);
		load_thread(4'd6, 8'd0, 8'd255);
		send_issue(4'd5, 8'h01, 1'b1);
		release_inputs();
		wait_drain();
		send_issue(4'd6, 8'hff, 1'b1);
		release_inputs();
		wait_drain();
		end_test();

		start_test("back_to_back");
		load_thread(4'd1, 8'd64, 8'd3);
		load_thread(4'd2, 8'd80, 8'd5);
		load_thread(4'd7, 8'd96, 8'd2);
		load_thread(4'd9, 8'd120, 8'd4);
		send_issue(4'd1, 8'h10, 1'b1);
		send_issue(4'd2, 8'h11, 1'b1);
		send_issue(4'd7, 8'h12, 1'b1);
		send_issue(4'd9, 8'h13, 1'b1);
		release_inputs();
		wait_drain();
		end_test();

		// Up to four strobes per round, never more than the queue holds
		start_test("random_traffic");
		for (int round = 0; round < 12; round++) begin
			n_req = $urandom_range(4, 1);
			for (int j = 0; j < n_req; j++) begin
				len		= len_t'($urandom_range(12, 1));
				base	= addr_t'($urandom_range(mpu_pkg::mem_depth - int'(len), 0));
				tids[j]	= tid_t'($urandom_range(mpu_pkg::thread_count - 1, 0));
				load_thread(tids[j], base, len);
			end
			for (int j = 0; j < n_req; j++) begin
				send_issue(tids[j], issue_no_t'($urandom), 1'b1);
			end
			release_inputs();
			wait_drain();
		end
		end_test();

		// First strobe goes straight to the controller, four fill the queue, the last is lost
		start_test("overflow");
		check({test_name, " overflow before"}, word_t'(0), word_t'(overflow));
		load_thread(4'd12, 8'd140, 8'd6);
		load_thread(4'd13, 8'd150, 8'd2);
		load_thread(4'd14, 8'd160, 8'd3);
		for (int j = 0; j < 6; j++) begin
			send_issue(tid_t'(12 + j % 3), issue_no_t'(8'h40 + j), j < 5);
		end
		release_inputs();
		@(negedge clock);
		check({test_name, " overflow set"}, word_t'(1), word_t'(overflow));
		wait_drain();
		repeat (20) @(posedge clock);		// Quiet period, dropped packet must not show
		check({test_name, " overflow sticky"}, word_t'(1), word_t'(overflow));
		end_test();

		// Reset lands in the middle of a long packet
		start_test("reset_recovery");
		send_issue(4'd6, 8'h5a, 1'b1);
		release_inputs();
		wait_valid();
		@(posedge clock);
		reset <= 1'b1;
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		exp_q.delete();						// Rest of the cut packet is never sent
		foreach (map_shadow[i]) begin
			map_shadow[i] = '0;				// Table clears on reset, memory keeps its data
		end
		@(negedge clock);
		check({test_name, " valid"}, word_t'(0), word_t'(dispatch.valid));
		check({test_name, " overflow"}, word_t'(0), word_t'(overflow));
		load_thread(4'd11, 8'd200, 8'd5);
		send_issue(4'd11, 8'h99, 1'b1);
		release_inputs();
		wait_drain();
		end_test();

		finish_run();
	end

endmodule

// ==== verification/mpu_dispatch_chk.sv ====
module mpu_dispatch_chk (
	input	logic						clock,
	input	logic						reset,
	input	logic						idle,
	input	logic						lookup_req,
	input	logic						lookup_ack,
	input	mpu_pkg::dispatch_out_t		dispatch
);

	timeunit 1ns;
	timeprecision 100ps;

	////////////////////////////////////////////////////////////////////////////
	// Output stream framing
	////////////////////////////////////////////////////////////////////////////

	a_contiguous: assert property (@(posedge clock) disable iff (reset)
		dispatch.valid & ~dispatch.last |=> dispatch.valid)
		else $error("packet word missing before the last word");

	a_last_valid: assert property (@(posedge clock) disable iff (reset)
		dispatch.last |-> dispatch.valid)
		else $error("last flag raised without a valid word");

	a_not_idle: assert property (@(posedge clock) disable iff (reset)
		dispatch.valid |-> ~idle)
		else $error("controller idle while a word goes out");

	// Map answers one cycle after the request
	a_ack_follows: assert property (@(posedge clock) disable iff (reset)
		lookup_req |=> lookup_ack)
		else $error("lookup ack missing one cycle after the request");

	a_ack_caused: assert property (@(posedge clock) disable iff (reset)
		lookup_ack |-> $past(lookup_req))
		else $error("lookup ack without a request the cycle before");

endmodule

bind dispatch_ctrl mpu_dispatch_chk u_dispatch_chk (
	.clock		(clock),
	.reset		(reset),
	.idle		(idle),
	.lookup_req	(lookup_req),
	.lookup_ack	(lookup_ack),
	.dispatch	(dispatch)
);

// ==== source/mpu_dispatch_top.sv ====
module mpu_dispatch_top (
	input	logic						clock,
	input	logic						reset,
	input	mpu_pkg::issue_req_t		issue,
	input	mpu_pkg::map_write_t		map_wr,
	input	mpu_pkg::mem_write_t		mem_wr,
	output	mpu_pkg::dispatch_out_t		dispatch,
	output	logic						overflow
);

	////////////////////////////////////////////////////////////////////////////
	// Interconnect
	////////////////////////////////////////////////////////////////////////////

	mpu_pkg::issue_req_t				next_req;
	logic								idle;

	logic								lookup_req;
	logic [mpu_pkg::thread_id_w-1:0]	lookup_id;
	logic								lookup_ack;
	mpu_pkg::lookup_t					info;

	logic								mem_rd_en;
	logic [mpu_pkg::addr_w-1:0]			mem_rd_addr;
	mpu_pkg::instr_t					rd_data;

	issue_queue u_issue_queue (
		.clock		(clock),
		.reset		(reset),
		.issue		(issue),
		.idle		(idle),
		.next_req	(next_req),
		.overflow	(overflow)
	);

	thread_map u_thread_map (
		.clock		(clock),
		.reset		(reset),
		.map_wr		(map_wr),
		.lookup_req	(lookup_req),
		.lookup_id	(lookup_id),
		.lookup_ack	(lookup_ack),
		.info		(info)
	);

	dispatch_ctrl u_dispatch_ctrl (
		.clock			(clock),
		.reset			(reset),
		.next_req		(next_req),
		.idle			(idle),
		.lookup_req		(lookup_req),
		.lookup_id		(lookup_id),
		.lookup_ack		(lookup_ack),
		.info			(info),
		.mem_rd_en		(mem_rd_en),
		.mem_rd_addr	(mem_rd_addr),
		.rd_data		(rd_data),
		.dispatch		(dispatch)
	);

	instr_mem u_instr_mem (
		.clock		(clock),
		.mem_wr		(mem_wr),
		.rd_en		(mem_rd_en),
		.rd_addr	(mem_rd_addr),
		.rd_data	(rd_data)
	);

endmodule

// ==== source/instr_mem.sv ====
module instr_mem (
	input	logic							clock,
	input	mpu_pkg::mem_write_t			mem_wr,
	input	logic							rd_en,
	input	logic [mpu_pkg::addr_w-1:0]		rd_addr,
	output	mpu_pkg::instr_t				rd_data
);

	mpu_pkg::instr_t	mem_q [mpu_pkg::mem_depth];

	// Host load
	always_ff @(posedge clock) begin
		if (mem_wr.valid) begin
			mem_q[mem_wr.addr] <= mem_wr.data;
		end
	end

	// Registered read, data one cycle after the enable
	always_ff @(posedge clock) begin
		if (rd_en) begin
			rd_data <= mem_q[rd_addr];
		end
	end

endmodule

// ==== source/dispatch_ctrl.sv ====
module dispatch_ctrl (
	input	logic								clock,
	input	logic								reset,
	input	mpu_pkg::issue_req_t				next_req,
	output	logic								idle,
	output	logic								lookup_req,
	output	logic [mpu_pkg::thread_id_w-1:0]	lookup_id,
	input	logic								lookup_ack,
	input	mpu_pkg::lookup_t					info,
	output	logic								mem_rd_en,
	output	logic [mpu_pkg::addr_w-1:0]			mem_rd_addr,
	input	mpu_pkg::instr_t					rd_data,
	output	mpu_pkg::dispatch_out_t				dispatch
);

	mpu_pkg::dispatch_state_e			state;

	// Captured request and thread info
	logic [mpu_pkg::thread_id_w-1:0]	tid_q;
	logic [mpu_pkg::issue_no_w-1:0]		issue_q;
	logic [mpu_pkg::len_w-1:0]			len_q;

	// Load counters
	logic [mpu_pkg::len_w-1:0]			rem_cnt;		// Reads still to issue
	logic [mpu_pkg::addr_w-1:0]			addr_q;
	logic								last_rd;

	// Read pipeline tags
	logic								ld_d1;
	logic								last_d1;

	logic								hdr_state;
	mpu_pkg::header_t					hdr_word;

	// Registered output word
	logic								out_valid;
	logic								out_header;
	logic								out_last;
	mpu_pkg::dispatch_word_u			out_word;

	assign idle			= state == mpu_pkg::st_idle;
	assign lookup_req	= state == mpu_pkg::st_lookup;
	assign lookup_id	= tid_q;

	assign hdr_state	= (state == mpu_pkg::st_send_tid) |
						  (state == mpu_pkg::st_send_issue) |
						  (state == mpu_pkg::st_send_len);

	// First read goes out with the length header, the rest in the load state
	assign mem_rd_en	= ((state == mpu_pkg::st_send_len) |
						   (state == mpu_pkg::st_send_instr)) & (rem_cnt != '0);
	assign mem_rd_addr	= addr_q;
	assign last_rd		= rem_cnt == {{(mpu_pkg::len_w-1){1'b0}}, 1'b1};

	////////////////////////////////////////////////////////////////////////////
	// FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= mpu_pkg::st_idle;
		end
		else begin
			case (state)
				mpu_pkg::st_idle: begin
					if (next_req.valid) begin
						state <= mpu_pkg::st_lookup;
					end
				end
				mpu_pkg::st_lookup:		state <= mpu_pkg::st_send_tid;		// Ack is fixed latency
				mpu_pkg::st_send_tid:	state <= mpu_pkg::st_send_issue;
				mpu_pkg::st_send_issue:	state <= mpu_pkg::st_send_len;
				mpu_pkg::st_send_len:	state <= mpu_pkg::st_send_instr;
				mpu_pkg::st_send_instr: begin
					// Stay until the final word leaves
					if (out_last) begin
						state <= mpu_pkg::st_idle;
					end
				end
				default:				state <= mpu_pkg::st_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (idle & next_req.valid) begin
			tid_q	<= next_req.thread_id;
			issue_q	<= next_req.issue_no;
		end
		if (lookup_ack) begin
			len_q	<= info.length;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			rem_cnt <= '0;
		end
		else if (lookup_ack) begin
			rem_cnt <= info.length;
		end
		else if (mem_rd_en) begin
			rem_cnt <= rem_cnt - 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (lookup_ack) begin
			addr_q <= info.base;
		end
		else if (mem_rd_en) begin
			addr_q <= addr_q + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Output word
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		hdr_word.unused	= '0;
		hdr_word.value	= '0;
		case (state)
			mpu_pkg::st_send_tid: begin
				hdr_word.kind								= mpu_pkg::hdr_thread_id;
				hdr_word.value[mpu_pkg::thread_id_w-1:0]	= tid_q;
			end
			mpu_pkg::st_send_issue: begin
				hdr_word.kind	= mpu_pkg::hdr_issue_no;
				hdr_word.value	= issue_q;
			end
			default: begin
				hdr_word.kind	= mpu_pkg::hdr_length;
				hdr_word.value	= len_q;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			ld_d1		<= 1'b0;
			last_d1		<= 1'b0;
			out_valid	<= 1'b0;
			out_header	<= 1'b0;
			out_last	<= 1'b0;
		end
		else begin
			ld_d1		<= mem_rd_en;				// Read data valid next cycle
			last_d1		<= mem_rd_en & last_rd;
			out_valid	<= hdr_state | ld_d1;
			out_header	<= hdr_state;
			out_last	<= last_d1;
		end
	end

	always_ff @(posedge clock) begin
		if (hdr_state) begin
			out_word.hdr	<= hdr_word;
		end
		else begin
			out_word.instr	<= rd_data;
		end
	end

	assign dispatch = '{
		valid:		out_valid,
		is_header:	out_header,
		last:		out_last,
		word:		out_word
	};

endmodule

// ==== source/thread_map.sv ====
module thread_map (
	input	logic							clock,
	input	logic							reset,
	input	mpu_pkg::map_write_t			map_wr,
	input	logic							lookup_req,
	input	logic [mpu_pkg::thread_id_w-1:0]	lookup_id,
	output	logic							lookup_ack,
	output	mpu_pkg::lookup_t				info
);

	mpu_pkg::lookup_t	table_q [mpu_pkg::thread_count];

	////////////////////////////////////////////////////////////////////////////
	// Host write port
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < mpu_pkg::thread_count; i++) begin
				table_q[i] <= '0;
			end
		end
		else if (map_wr.valid) begin
			table_q[map_wr.thread_id].base		<= map_wr.base;
			table_q[map_wr.thread_id].length	<= map_wr.length;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Lookup port, answer one cycle after the request
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			lookup_ack <= 1'b0;
		end
		else begin
			lookup_ack <= lookup_req;
		end
	end

	// Result held between lookups
	always_ff @(posedge clock) begin
		if (lookup_req) begin
			info <= table_q[lookup_id];
		end
	end

endmodule

// ==== source/issue_queue.sv ====
module issue_queue (
	input	logic					clock,
	input	logic					reset,
	input	mpu_pkg::issue_req_t	issue,
	input	logic					idle,
	output	mpu_pkg::issue_req_t	next_req,
	output	logic					overflow
);

	mpu_pkg::issue_req_t				entries [mpu_pkg::queue_depth];

	logic [mpu_pkg::queue_ptr_w-1:0]	rd_ptr;
	logic [mpu_pkg::queue_ptr_w-1:0]	wr_ptr;
	logic [mpu_pkg::queue_cnt_w-1:0]	count;

	logic								empty;
	logic								full;
	logic								push;
	logic								pop;

	assign empty	= count == '0;
	assign full		= count == mpu_pkg::queue_full;
	assign push		= issue.valid & ~full;		// Dropped when full
	assign pop		= idle & ~empty;

	// Head entry, valid only as the pop strobe
	always_comb begin
		next_req		= entries[rd_ptr];
		next_req.valid	= pop;
	end

	always_ff @(posedge clock) begin
		if (push) begin
			entries[wr_ptr] <= issue;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			rd_ptr	<= '0;
			wr_ptr	<= '0;
		end
		else begin
			if (push) begin
				wr_ptr <= (wr_ptr == mpu_pkg::queue_last) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == mpu_pkg::queue_last) ? '0 : rd_ptr + 1'b1;
			end
		end
	end

	// Occupancy, push and pop may coincide
	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
		end
		else begin
			case ({push, pop})
				2'b10:		count <= count + 1'b1;
				2'b01:		count <= count - 1'b1;
				default:	count <= count;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			overflow <= 1'b0;
		end
		else if (issue.valid & full) begin
			overflow <= 1'b1;		// Sticky until reset
		end
	end

endmodule

// ==== source/mpu_pkg.sv ====
package mpu_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths and sizes
	////////////////////////////////////////////////////////////////////////////

	localparam int thread_id_w	= 4;			// 16 threads
	localparam int issue_no_w	= 8;
	localparam int addr_w		= 8;			// 256 instruction words
	localparam int len_w		= 8;
	localparam int word_w		= 32;
	localparam int queue_depth	= 4;

	localparam int thread_count	= 1 << thread_id_w;
	localparam int mem_depth	= 1 << addr_w;
	localparam int queue_ptr_w	= $clog2(queue_depth);
	localparam int queue_cnt_w	= queue_ptr_w + 1;

	localparam int hdr_kind_w	= 2;
	localparam int hdr_value_w	= 8;

	localparam logic [queue_ptr_w-1:0] queue_last = queue_ptr_w'(queue_depth - 1);
	localparam logic [queue_cnt_w-1:0] queue_full = queue_cnt_w'(queue_depth);

	////////////////////////////////////////////////////////////////////////////
	// Host side and issue side transfers
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic						valid;
		logic [thread_id_w-1:0]		thread_id;
		logic [issue_no_w-1:0]		issue_no;
	} issue_req_t;

	typedef struct packed {
		logic						valid;
		logic [thread_id_w-1:0]		thread_id;
		logic [addr_w-1:0]			base;
		logic [len_w-1:0]			length;
	} map_write_t;

	// Thread info returned by the map
	typedef struct packed {
		logic [addr_w-1:0]			base;
		logic [len_w-1:0]			length;
	} lookup_t;

	typedef struct packed {
		logic [7:0]					opcode;
		logic [3:0]					dst;
		logic [3:0]					src1;
		logic [3:0]					src2;
		logic [11:0]				imm;
	} instr_t;

	typedef struct packed {
		logic						valid;
		logic [addr_w-1:0]			addr;
		instr_t						data;
	} mem_write_t;

	////////////////////////////////////////////////////////////////////////////
	// Output stream
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [hdr_kind_w-1:0] {
		hdr_thread_id	= 2'd0,
		hdr_issue_no	= 2'd1,
		hdr_length		= 2'd2
	} hdr_kind_e;

	typedef struct packed {
		hdr_kind_e									kind;
		logic [word_w-hdr_kind_w-hdr_value_w-1:0]	unused;		// Always zero
		logic [hdr_value_w-1:0]						value;
	} header_t;

	// Same 32 bits, read as instruction or header field
	typedef union packed {
		instr_t						instr;
		header_t					hdr;
	} dispatch_word_u;

	typedef struct packed {
		logic						valid;
		logic						is_header;
		logic						last;		// Final word of a packet
		dispatch_word_u				word;
	} dispatch_out_t;

	typedef enum logic [2:0] {
		st_idle,
		st_lookup,
		st_send_tid,
		st_send_issue,
		st_send_len,
		st_send_instr
	} dispatch_state_e;

endpackage
